//--- hw/axi_mem_pkg.sv
/* axi slave memory model shared types
   bus field widths, response codes, memory map and engine states */
package axi_mem_pkg;

	typedef logic [31:0] addr_t; // byte address
	typedef logic [31:0] data_t; // one beat
	typedef logic [3:0]  strb_t; // one bit per byte lane
	typedef logic [3:0]  id_t;
	typedef logic [7:0]  len_t;  // beats minus one
	typedef logic [2:0]  size_t; // log2 bytes per beat

	typedef enum logic [1:0] {
		FIXED = 2'b00,
		INCR  = 2'b01,
		WRAP  = 2'b10 // answered with SLVERR
	} burst_e;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01, // never returned, no exclusive monitor
		SLVERR = 2'b10,
		DECERR = 2'b11
	} resp_e;

	typedef enum logic {
		R_IDLE,
		R_BEAT
	} rd_state_e;

	typedef enum logic [1:0] {
		W_IDLE,
		W_BEAT,
		W_RESP
	} wr_state_e;

	// memory map
	localparam addr_t MEM_BASE   = 32'h8000_0000;
	localparam addr_t MTIME_BASE = 32'ha000_0048; // low word, high word at +4

	// beat address, same rule for reads and writes
	// wrap bursts never touch memory so they just sit on the start address
	function automatic addr_t beat_addr(addr_t start, len_t idx, size_t size, burst_e burst);
		addr_t step;
		step = addr_t'(idx) << size;
		return (burst == INCR) ? start + step : start;
	endfunction

endpackage

//--- hw/axi_req_if.sv
/* one queued burst request, queue head to engine
   valid/ready handshake, fields held while valid */
`timescale 1ns/1ps

interface axi_req_if;
	import axi_mem_pkg::*;

	logic   valid; // head entry present
	logic   ready; // engine takes it this cycle
	addr_t  addr;
	id_t    id;
	len_t   len;
	size_t  size;
	burst_e burst;

	// queue side
	modport source (
		output valid, addr, id, len, size, burst,
		input  ready
	);

	// engine side
	modport sink (
		input  valid, addr, id, len, size, burst,
		output ready
	);

endinterface

//--- hw/axi_req_queue.sv
/* circular request queue for the AR or AW channel
   accepts on valid/ready, presents the oldest entry at the head */
`timescale 1ns/1ps

module axi_req_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                in_valid,
	output logic                in_ready,
	input  axi_mem_pkg::addr_t  in_addr,
	input  axi_mem_pkg::id_t    in_id,
	input  axi_mem_pkg::len_t   in_len,
	input  axi_mem_pkg::size_t  in_size,
	input  axi_mem_pkg::burst_e in_burst,
	axi_req_if.source           head
);
	import axi_mem_pkg::*;

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1); // holds 0..QUEUE_DEPTH

	addr_t  q_addr [QUEUE_DEPTH];
	id_t    q_id [QUEUE_DEPTH];
	len_t   q_len [QUEUE_DEPTH];
	size_t  q_size [QUEUE_DEPTH];
	burst_e q_burst [QUEUE_DEPTH];

	logic [PTR_W-1:0] rd_ptr; // oldest entry
	logic [PTR_W-1:0] wr_ptr; // next free slot
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;
	logic             push;
	logic             pop;

	assign push = in_valid && in_ready;
	assign pop  = head.valid && head.ready;

	// occupancy after this edge
	always_comb begin
		count_next = count;
		if (push && !pop)
			count_next = count + 1'b1;
		else if (pop && !push)
			count_next = count - 1'b1;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rd_ptr   <= '0;
			wr_ptr   <= '0;
			count    <= '0;
			in_ready <= 1'b0; // held low through reset
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count    <= count_next;
			in_ready <= (count_next != CNT_W'(QUEUE_DEPTH)); // not full next cycle
		end
	end

	// entry storage
	always_ff @(posedge clock) begin
		if (push) begin
			q_addr[wr_ptr]  <= in_addr;
			q_id[wr_ptr]    <= in_id;
			q_len[wr_ptr]   <= in_len;
			q_size[wr_ptr]  <= in_size;
			q_burst[wr_ptr] <= in_burst;
		end
	end

	assign head.valid = (count != '0);
	assign head.addr  = q_addr[rd_ptr];
	assign head.id    = q_id[rd_ptr];
	assign head.len   = q_len[rd_ptr];
	assign head.size  = q_size[rd_ptr];
	assign head.burst = q_burst[rd_ptr];

endmodule

//--- hw/mem_map.sv
/* address map behind the engines: byte-lane main memory and mtime
   combinational word read, strobed write at the clock edge */
`timescale 1ns/1ps

module mem_map #(
	parameter int MEM_WORDS = 1024
) (
	input  logic               clock,
	input  logic               reset,
	input  axi_mem_pkg::addr_t rd_addr,
	output axi_mem_pkg::data_t rd_data,
	output logic               rd_hit,
	input  logic               wr_en,
	input  axi_mem_pkg::addr_t wr_addr,
	input  axi_mem_pkg::data_t wr_data,
	input  axi_mem_pkg::strb_t wr_strb,
	output logic               wr_hit
);
	import axi_mem_pkg::*;

	localparam int    IDX_W     = $clog2(MEM_WORDS);
	localparam addr_t MEM_BYTES = addr_t'(MEM_WORDS * 4);

	logic [3:0][7:0]  mem [MEM_WORDS]; // byte lanes per word
	logic [63:0]      mtime;
	addr_t            rd_off;
	addr_t            wr_off;
	logic             rd_mem;
	logic             rd_timer;
	logic [IDX_W-1:0] rd_idx;
	logic [IDX_W-1:0] wr_idx;

	// main memory comes up cleared
	initial begin
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = '0;
	end

	// offset wraps high below MEM_BASE, so one compare covers both ends
	assign rd_off   = rd_addr - MEM_BASE;
	assign wr_off   = wr_addr - MEM_BASE;
	assign rd_mem   = (rd_off < MEM_BYTES);
	assign rd_timer = (rd_addr[31:3] == MTIME_BASE[31:3]); // 8 byte window
	assign rd_idx   = rd_off[IDX_W+1:2]; // word aligned
	assign wr_idx   = wr_off[IDX_W+1:2];

	assign rd_hit = rd_mem || rd_timer;
	assign wr_hit = (wr_off < MEM_BYTES); // timer is read only

	always_comb begin
		if (rd_mem)
			rd_data = mem[rd_idx];
		else if (rd_timer)
			rd_data = rd_addr[2] ? mtime[63:32] : mtime[31:0]; // high word at +4
		else
			rd_data = '0; // unmapped
	end

	always_ff @(posedge clock) begin
		if (wr_en && wr_hit) begin
			for (int b = 0; b < 4; b++) begin
				if (wr_strb[b])
					mem[wr_idx][b] <= wr_data[8*b +: 8];
			end
		end
	end

	// free running machine timer
	always_ff @(posedge clock) begin
		if (reset)
			mtime <= '0;
		else
			mtime <= mtime + 64'd1;
	end

endmodule

//--- hw/axi_read_engine.sv
/* R channel sequencer, pops one AR request and streams its beats
   beat n+1 is fetched at the edge where beat n transfers */
`timescale 1ns/1ps

module axi_read_engine (
	input  logic               clock,
	input  logic               reset,
	axi_req_if.sink            req,
	output logic               rvalid,
	output axi_mem_pkg::data_t rdata,
	output axi_mem_pkg::resp_e rresp,
	output axi_mem_pkg::id_t   rid,
	output logic               rlast,
	input  logic               rready,
	output axi_mem_pkg::addr_t rd_addr,
	input  axi_mem_pkg::data_t rd_data,
	input  logic               rd_hit
);
	import axi_mem_pkg::*;

	rd_state_e state;
	len_t      beat;      // index of the beat on the bus
	len_t      next_beat;
	addr_t     cur_addr;  // captured request
	len_t      cur_len;
	size_t     cur_size;
	burst_e    cur_burst;
	burst_e    fetch_burst;
	data_t     beat_data;
	resp_e     beat_resp;
	logic      pop;
	logic      advance;

	assign req.ready = (state == R_IDLE);
	assign pop       = req.valid && req.ready;
	assign rvalid    = (state == R_BEAT);
	assign advance   = rvalid && rready && !rlast; // more beats to go
	assign next_beat = beat + 1'b1;

	// idle fetches beat 0 of the head, otherwise the following beat
	always_comb begin
		if (state == R_IDLE) begin
			rd_addr     = req.addr;
			fetch_burst = req.burst;
		end else begin
			rd_addr     = beat_addr(cur_addr, next_beat, cur_size, cur_burst);
			fetch_burst = cur_burst;
		end
	end

	assign beat_data = (fetch_burst == WRAP) ? '0 : rd_data;
	assign beat_resp = (fetch_burst == WRAP) ? SLVERR : (rd_hit ? OKAY : DECERR);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= R_IDLE;
			beat  <= '0;
		end else begin
			case (state)
				R_IDLE: begin
					if (pop) begin
						state <= R_BEAT;
						beat  <= '0;
					end
				end
				R_BEAT: begin
					if (rready && rlast)
						state <= R_IDLE; // one idle cycle before next pop
					else if (advance)
						beat <= next_beat;
				end
				default: state <= R_IDLE;
			endcase
		end
	end

	// request capture and beat payload
	always_ff @(posedge clock) begin
		if (pop) begin
			cur_addr  <= req.addr;
			cur_len   <= req.len;
			cur_size  <= req.size;
			cur_burst <= req.burst;
			rid       <= req.id;
			rdata     <= beat_data;
			rresp     <= beat_resp;
			rlast     <= (req.len == '0); // single beat burst
		end else if (advance) begin
			rdata <= beat_data;
			rresp <= beat_resp;
			rlast <= (next_beat == cur_len);
		end
	end

endmodule

//--- hw/axi_write_engine.sv
/* W and B channel sequencer, writes each beat of the popped AW burst
   and returns one worst-case response per burst */
`timescale 1ns/1ps

module axi_write_engine (
	input  logic               clock,
	input  logic               reset,
	axi_req_if.sink            req,
	input  logic               wvalid,
	input  axi_mem_pkg::data_t wdata,
	input  axi_mem_pkg::strb_t wstrb,
	input  logic               wlast,  // beat count ends the burst instead
	output logic               wready,
	output logic               bvalid,
	output axi_mem_pkg::resp_e bresp,
	output axi_mem_pkg::id_t   bid,
	input  logic               bready,
	output logic               wr_en,
	output axi_mem_pkg::addr_t wr_addr,
	output axi_mem_pkg::data_t wr_data,
	output axi_mem_pkg::strb_t wr_strb,
	input  logic               wr_hit
);
	import axi_mem_pkg::*;

	wr_state_e state;
	len_t      beat;      // index of the next beat expected
	addr_t     cur_addr;  // captured request
	len_t      cur_len;
	size_t     cur_size;
	burst_e    cur_burst;
	logic      pop;
	logic      beat_xfer;
	logic      last_beat;

	assign req.ready = (state == W_IDLE);
	assign pop       = req.valid && req.ready;
	assign wready    = (state == W_BEAT);
	assign bvalid    = (state == W_RESP);
	assign beat_xfer = wvalid && wready;
	assign last_beat = (beat == cur_len);

	// memory port, wrap bursts never write
	assign wr_addr = beat_addr(cur_addr, beat, cur_size, cur_burst);
	assign wr_data = wdata;
	assign wr_strb = wstrb;
	assign wr_en   = beat_xfer && (cur_burst != WRAP);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= W_IDLE;
			beat  <= '0;
		end else begin
			case (state)
				W_IDLE: begin
					if (pop) begin
						state <= W_BEAT;
						beat  <= '0;
					end
				end
				W_BEAT: begin
					if (beat_xfer) begin
						if (last_beat)
							state <= W_RESP;
						else
							beat <= beat + 1'b1;
					end
				end
				W_RESP: begin
					if (bready)
						state <= W_IDLE;
				end
				default: state <= W_IDLE;
			endcase
		end
	end

	// request capture and response accumulation
	always_ff @(posedge clock) begin
		if (pop) begin
			cur_addr  <= req.addr;
			cur_len   <= req.len;
			cur_size  <= req.size;
			cur_burst <= req.burst;
			bid       <= req.id;
			bresp     <= (req.burst == WRAP) ? SLVERR : OKAY;
		end else if (beat_xfer && !wr_hit && bresp == OKAY) begin
			bresp <= DECERR; // sticky, any miss fails the burst
		end
	end

endmodule

//--- hw/axi_mem_top.sv
/* AXI4 slave memory model top
   AR/AW request queues feeding the read and write engines over one memory map */
`timescale 1ns/1ps

module axi_mem_top #(
	parameter int MEM_WORDS   = 1024,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                clock,
	input  logic                reset,
	// AR
	input  axi_mem_pkg::addr_t  araddr,
	input  logic                arvalid,
	output logic                arready,
	input  axi_mem_pkg::id_t    arid,
	input  axi_mem_pkg::len_t   arlen,
	input  axi_mem_pkg::size_t  arsize,
	input  axi_mem_pkg::burst_e arburst,
	// R
	output axi_mem_pkg::data_t  rdata,
	output axi_mem_pkg::resp_e  rresp,
	output logic                rvalid,
	input  logic                rready,
	output logic                rlast,
	output axi_mem_pkg::id_t    rid,
	// AW
	input  axi_mem_pkg::addr_t  awaddr,
	input  logic                awvalid,
	output logic                awready,
	input  axi_mem_pkg::id_t    awid,
	input  axi_mem_pkg::len_t   awlen,
	input  axi_mem_pkg::size_t  awsize,
	input  axi_mem_pkg::burst_e awburst,
	// W
	input  axi_mem_pkg::data_t  wdata,
	input  axi_mem_pkg::strb_t  wstrb,
	input  logic                wvalid,
	output logic                wready,
	input  logic                wlast,
	// B
	output axi_mem_pkg::resp_e  bresp,
	output logic                bvalid,
	input  logic                bready,
	output axi_mem_pkg::id_t    bid
);
	import axi_mem_pkg::*;

	addr_t rd_addr; // read engine to memory map
	data_t rd_data;
	logic  rd_hit;
	logic  wr_en;   // write engine to memory map
	addr_t wr_addr;
	data_t wr_data;
	strb_t wr_strb;
	logic  wr_hit;

	axi_req_if ar_req ();
	axi_req_if aw_req ();

	axi_req_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) ar_queue (
		.clock(clock), .reset(reset),
		.in_valid(arvalid), .in_ready(arready),
		.in_addr(araddr), .in_id(arid), .in_len(arlen), .in_size(arsize), .in_burst(arburst),
		.head(ar_req)
	);

	axi_req_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) aw_queue (
		.clock(clock), .reset(reset),
		.in_valid(awvalid), .in_ready(awready),
		.in_addr(awaddr), .in_id(awid), .in_len(awlen), .in_size(awsize), .in_burst(awburst),
		.head(aw_req)
	);

	axi_read_engine i_read_engine (
		.clock(clock), .reset(reset), .req(ar_req),
		.rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rid(rid), .rlast(rlast),
		.rready(rready),
		.rd_addr(rd_addr), .rd_data(rd_data), .rd_hit(rd_hit)
	);

	axi_write_engine i_write_engine (
		.clock(clock), .reset(reset), .req(aw_req),
		.wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wready(wready),
		.bvalid(bvalid), .bresp(bresp), .bid(bid), .bready(bready),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .wr_strb(wr_strb),
		.wr_hit(wr_hit)
	);

	mem_map #(.MEM_WORDS(MEM_WORDS)) i_mem_map (
		.clock(clock), .reset(reset),
		.rd_addr(rd_addr), .rd_data(rd_data), .rd_hit(rd_hit),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .wr_strb(wr_strb),
		.wr_hit(wr_hit)
	);

endmodule

//--- verification/tb_clock.sv
/* testbench clock and reset source
   free running clock, reset held for the first few cycles */
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 3
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD_NS / 2) clock = ~clock;
	end

	// released on a falling edge, away from the sampling edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(negedge clock);
		reset = 1'b0;
	end

endmodule

//--- verification/axi_mem_asserts.sv
/* AXI handshake assertions bound into the memory model top
   valid hold, stalled read data and the state right after reset */
`timescale 1ns/1ps

module axi_mem_asserts (
	input logic               clock,
	input logic               reset,
	input logic               arready,
	input logic               awready,
	input logic               rvalid,
	input logic               rready,
	input axi_mem_pkg::data_t rdata,
	input logic               wready,
	input logic               bvalid,
	input logic               bready
);

	int assert_failures = 0; // summed into the testbench result

	// read beat waits for its ready
	rvalid_hold: assert property (@(posedge clock) disable iff (reset)
		rvalid && !rready |=> rvalid)
		else begin
			$error("rvalid dropped before rready");
			assert_failures++;
		end

	rdata_stable: assert property (@(posedge clock) disable iff (reset)
		rvalid && !rready |=> $stable(rdata))
		else begin
			$error("rdata changed while the beat was stalled");
			assert_failures++;
		end

	// write response held until bready
	bvalid_hold: assert property (@(posedge clock) disable iff (reset)
		bvalid && !bready |=> bvalid)
		else begin
			$error("bvalid dropped before bready");
			assert_failures++;
		end

	// all handshake outputs idle coming out of reset
	reset_idle: assert property (@(posedge clock)
		reset |=> !arready && !awready && !rvalid && !wready && !bvalid)
		else begin
			$error("handshake output high right after reset");
			assert_failures++;
		end

endmodule

bind axi_mem_top axi_mem_asserts i_asserts (
	.clock(clock),
	.reset(reset),
	.arready(arready),
	.awready(awready),
	.rvalid(rvalid),
	.rready(rready),
	.rdata(rdata),
	.wready(wready),
	.bvalid(bvalid),
	.bready(bready)
);

//--- verification/axi_mem_tb.sv
/* testbench for the AXI4 slave memory model
   random bursts checked against a byte model of main memory */
`timescale 1ns/1ps

module axi_mem_tb;
	import axi_mem_pkg::*;

	localparam int    MEM_WORDS   = 256;
	localparam int    QUEUE_DEPTH = 4;
	localparam int    SEED        = 91000;
	localparam int    MAX_BEATS   = 16;
	localparam int    N_RANDOM    = 12;
	localparam int    N_BURSTS    = 2 * N_RANDOM + 16; // directed tests add 16
	localparam int    WATCHDOG_NS = N_BURSTS * (MAX_BEATS + 20) * 8;
	localparam size_t BEAT_SIZE   = 3'd2; // 4 bytes per beat
	localparam addr_t MEM_END     = MEM_BASE + addr_t'(MEM_WORDS * 4);
	localparam addr_t UNMAPPED    = 32'h1000_0000;

	logic   clock;
	logic   reset;
	addr_t  araddr, awaddr;
	id_t    arid, awid, rid, bid;
	len_t   arlen, awlen;
	size_t  arsize, awsize;
	burst_e arburst, awburst;
	logic   arvalid, arready, awvalid, awready;
	logic   rvalid, rready, rlast;
	logic   wvalid, wready, wlast;
	logic   bvalid, bready;
	data_t  rdata, wdata;
	strb_t  wstrb;
	resp_e  rresp, bresp;

	logic [7:0] model_mem [MEM_WORDS * 4]; // mirror of main memory
	data_t      last_rdata;                // last beat seen on R
	int         data_errors, resp_errors, id_errors, last_errors, other_errors;

	tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(3)) i_clock (.clock(clock), .reset(reset));

	axi_mem_top #(.MEM_WORDS(MEM_WORDS), .QUEUE_DEPTH(QUEUE_DEPTH)) i_dut (.*);

	task automatic check_data(string name, data_t got, data_t exp);
		if (got !== exp) begin
			data_errors++;
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_resp(string name, resp_e got, resp_e exp);
		if (got !== exp) begin
			resp_errors++;
			$display("mismatch at %0t ns: %s got %s expected %s", $time, name,
				got.name(), exp.name());
		end
	endtask

	task automatic check_id(string name, id_t got, id_t exp);
		if (got !== exp) begin
			id_errors++;
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_last(string name, logic got, logic exp);
		if (got !== exp) begin
			last_errors++;
			$display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	function automatic logic in_mem(addr_t a);
		return (a >= MEM_BASE) && (a < MEM_END);
	endfunction

	function automatic logic in_timer(addr_t a);
		return (a >= MTIME_BASE) && (a < MTIME_BASE + 32'd8); // low and high word
	endfunction

	// FIXED stays on the start address, INCR steps one beat size per beat
	function automatic addr_t model_addr(addr_t start, int n, burst_e burst);
		if (burst == INCR)
			return start + addr_t'(n * (1 << BEAT_SIZE));
		return start;
	endfunction

	function automatic data_t model_word(addr_t a);
		int base;
		base = int'((a - MEM_BASE) & ~32'd3);
		return {model_mem[base + 3], model_mem[base + 2], model_mem[base + 1], model_mem[base]};
	endfunction

	task automatic model_write(addr_t a, data_t d, strb_t s);
		int base;
		base = int'((a - MEM_BASE) & ~32'd3);
		for (int b = 0; b < 4; b++) begin
			if (s[b])
				model_mem[base + b] = d[8*b +: 8]; // lane b is byte b
		end
	endtask

	// every bus task starts and ends on a falling edge
	task automatic ar_send(addr_t addr, id_t id, len_t len, burst_e burst);
		araddr  = addr;
		arid    = id;
		arlen   = len;
		arsize  = BEAT_SIZE;
		arburst = burst;
		arvalid = 1'b1;
		while (!arready)
			@(negedge clock);
		@(negedge clock); // accepted at the edge in between
		arvalid = 1'b0;
	endtask

	task automatic aw_send(addr_t addr, id_t id, len_t len, burst_e burst);
		awaddr  = addr;
		awid    = id;
		awlen   = len;
		awsize  = BEAT_SIZE;
		awburst = burst;
		awvalid = 1'b1;
		while (!awready)
			@(negedge clock);
		@(negedge clock);
		awvalid = 1'b0;
	endtask

	// takes len+1 beats with random rready stalls
	task automatic r_collect(addr_t addr, id_t id, len_t len, burst_e burst);
		int    i;
		addr_t a;
		data_t exp_d;
		resp_e exp_r;
		logic  timer_low;
		i = 0;
		while (i <= int'(len)) begin
			rready = ($urandom_range(3) != 0);
			if (rvalid && rready) begin
				a         = model_addr(addr, i, burst);
				timer_low = (burst != WRAP) && in_timer(a) && !a[2]; // free running
				exp_d     = '0;
				if (burst == WRAP)
					exp_r = SLVERR;
				else if (in_mem(a)) begin
					exp_d = model_word(a);
					exp_r = OKAY;
				end else if (in_timer(a))
					exp_r = OKAY; // high word still zero this early
				else
					exp_r = DECERR;
				check_resp("rresp", rresp, exp_r);
				if (!timer_low)
					check_data("rdata", rdata, exp_d);
				check_id("rid", rid, id);
				check_last("rlast", rlast, (i == int'(len)));
				last_rdata = rdata;
				i++;
			end
			@(negedge clock);
		end
		rready = 1'b0;
	endtask

	task automatic read_burst(addr_t addr, id_t id, len_t len, burst_e burst);
		ar_send(addr, id, len, burst);
		r_collect(addr, id, len, burst);
	endtask

	task automatic write_burst(addr_t addr, id_t id, len_t len, burst_e burst);
		data_t d [MAX_BEATS];
		strb_t s [MAX_BEATS];
		resp_e exp;
		addr_t a;
		logic  done;
		exp = (burst == WRAP) ? SLVERR : OKAY;
		for (int i = 0; i <= int'(len); i++) begin
			d[i] = data_t'($urandom);
			s[i] = strb_t'($urandom_range(15));
			a    = model_addr(addr, i, burst);
			if (burst != WRAP) begin // wrap writes are dropped
				if (in_mem(a))
					model_write(a, d[i], s[i]);
				else
					exp = DECERR;
			end
		end
		aw_send(addr, id, len, burst);
		for (int i = 0; i <= int'(len); i++) begin
			wdata  = d[i];
			wstrb  = s[i];
			wlast  = (i == int'(len));
			wvalid = 1'b1;
			while (!wready)
				@(negedge clock);
			@(negedge clock);
		end
		wvalid = 1'b0;
		wlast  = 1'b0;
		done   = 1'b0;
		while (!done) begin
			bready = ($urandom_range(3) != 0);
			if (bvalid && bready) begin
				check_resp("bresp", bresp, exp);
				check_id("bid", bid, id);
				done = 1'b1;
			end
			@(negedge clock);
		end
		bready = 1'b0;
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout after %0d ns, a handshake never completed", WATCHDOG_NS);
		$display("** FAIL **");
		$finish;
	end

	initial begin
		addr_t addr;
		len_t  len;
		id_t   id;
		data_t first_low;
		addr_t q_addr [QUEUE_DEPTH + 1];
		len_t  q_len [QUEUE_DEPTH + 1];
		int    total;
		araddr  = '0;
		arid    = '0;
		arlen   = '0;
		arsize  = BEAT_SIZE;
		arburst = INCR;
		arvalid = 1'b0;
		awaddr  = '0;
		awid    = '0;
		awlen   = '0;
		awsize  = BEAT_SIZE;
		awburst = INCR;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		wlast   = 1'b0;
		rready  = 1'b0;
		bready  = 1'b0;
		foreach (model_mem[i])
			model_mem[i] = '0; // memory powers up cleared
		void'($urandom(SEED));
		wait (!reset);
		@(negedge clock);

		// random INCR write, then read back the same range
		for (int n = 0; n < N_RANDOM; n++) begin
			len  = len_t'($urandom_range(MAX_BEATS - 1));
			addr = MEM_BASE + addr_t'($urandom_range(MEM_WORDS - MAX_BEATS) * 4);
			id   = id_t'($urandom);
			write_burst(addr, id, len, INCR);
			read_burst(addr, id_t'(id + 4'd1), len, INCR);
		end

		// FIXED bursts all land on one word
		addr = MEM_BASE + 32'h40;
		write_burst(addr, 4'h3, 8'd3, FIXED);
		read_burst(addr, 4'h4, 8'd3, FIXED);

		// machine timer
		read_burst(MTIME_BASE + 32'd4, 4'h6, 8'd0, INCR);
		read_burst(MTIME_BASE, 4'h7, 8'd0, INCR);
		first_low = last_rdata;
		read_burst(MTIME_BASE, 4'h8, 8'd0, INCR);
		if (!(last_rdata > first_low)) begin
			other_errors++;
			$display("timer low word did not increase: %h then %h", first_low, last_rdata);
		end
		write_burst(MTIME_BASE, 4'h9, 8'd0, INCR); // read only, DECERR

		// unmapped region and WRAP bursts
		write_burst(UNMAPPED, 4'ha, 8'd2, INCR);
		read_burst(UNMAPPED, 4'hb, 8'd2, INCR);
		addr = MEM_BASE + 32'h80;
		write_burst(addr, 4'hc, 8'd3, WRAP);
		read_burst(addr, 4'hd, 8'd3, WRAP);
		read_burst(addr, 4'he, 8'd3, INCR); // untouched by the wrap write

		// fill the AR queue with R stalled
		rready = 1'b0;
		for (int n = 0; n <= QUEUE_DEPTH; n++) begin
			q_addr[n] = MEM_BASE + addr_t'($urandom_range(MEM_WORDS - MAX_BEATS) * 4);
			q_len[n]  = len_t'($urandom_range(3));
			ar_send(q_addr[n], id_t'(n), q_len[n], INCR);
		end
		// engine holds the first burst, the queue the other QUEUE_DEPTH
		repeat (3) begin
			if (arready) begin
				other_errors++;
				$display("arready still high at %0t ns with the AR queue full", $time);
			end
			@(negedge clock);
		end
		for (int n = 0; n <= QUEUE_DEPTH; n++)
			r_collect(q_addr[n], id_t'(n), q_len[n], INCR);

		total = data_errors + resp_errors + id_errors + last_errors + other_errors
			+ i_dut.i_asserts.assert_failures;
		$display("errors: data %0d resp %0d id %0d last %0d other %0d assert %0d",
			data_errors, resp_errors, id_errors, last_errors, other_errors,
			i_dut.i_asserts.assert_failures);
		if (total == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- axi_mem.f
hw/axi_mem_pkg.sv
hw/axi_req_if.sv
hw/axi_req_queue.sv
hw/mem_map.sv
hw/axi_read_engine.sv
hw/axi_write_engine.sv
hw/axi_mem_top.sv
verification/tb_clock.sv
verification/axi_mem_asserts.sv
verification/axi_mem_tb.sv

//--- Makefile
# Verilator build and run of the AXI memory model testbench

VERILATOR ?= verilator
TOP       ?= axi_mem_tb
FILELIST  ?= axi_mem.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass only if the pass line is printed"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
